/* include/video_params.svh */
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// horizontal raster in pixel clocks
`define VID_H_ACTIVE 32
`define VID_H_FRONT  2
`define VID_H_SYNC   4
`define VID_H_BACK   2

// vertical raster in lines
`define VID_V_ACTIVE 8
`define VID_V_FRONT  1
`define VID_V_SYNC   2
`define VID_V_BACK   1

// video memory depth in 32-bit words
`define VID_RAM_WORDS 4096

// register byte addresses, bit 14 set
`define VID_REG_CTRL 16'h4000
`define VID_REG_BASE 16'h4004
`define VID_REG_PAL  16'h4040

`endif

/* src/video_pkg.sv */
`default_nettype none

package video_pkg;

    // cpu and memory word
    typedef logic [31:0] word_t;

    // red in 11:8, green in 7:4, blue in 3:0
    typedef logic [11:0] rgb444_t;

    // one video word, seen either as eight palette indices
    // or as two RGB565 pixels; pixel 0 sits in the low bits
    typedef union packed {
        logic [7:0][3:0]  idx;
        logic [1:0][15:0] rgb565;
    } video_word_u;

endpackage

`default_nettype wire

/* src/video_ifs.sv */
`default_nettype none

interface reg_bus_if
    import video_pkg::*;
    ();
    logic        sel;
    logic [15:0] offset;
    word_t       wdata;
    logic        write;
    word_t       rdata;

    modport master (output sel, offset, wdata, write, input rdata);
    modport slave (input sel, offset, wdata, write, output rdata);
endinterface

interface video_cfg_if
    import video_pkg::*;
    ();
    logic               enable;
    logic               mode;
    logic [11:0]        fb_base;
    rgb444_t [15:0]     palette;

    modport source (output enable, mode, fb_base, palette);
    modport sink (input enable, mode, fb_base, palette);
endinterface

`default_nettype wire

/* src/video_ram.sv */
`default_nettype none

`include "video_params.svh"

module video_ram
    import video_pkg::*;
    (
        // cpu port
        input  wire logic        cpu_clk_i,
        input  wire logic        cpu_chip_select_i,
        input  wire word_t       cpu_addr_i,
        input  wire word_t       cpu_write_data_i,
        input  wire logic [ 3:0] cpu_write_mask_i,
        output wire word_t       cpu_read_data_o,

        // pixel port, read only
        input  wire logic        pxl_clk_i,
        input  wire logic        pxl_chip_select_i,
        input  wire logic [11:0] pxl_addr_i,
        output wire word_t       pxl_data_o
    );

    word_t mem_r [0:`VID_RAM_WORDS-1] = '{default: '0};

    logic [11:0] cpu_index;
    word_t       cpu_read_data_r;
    word_t       pxl_data_r;

    // byte address to word index
    assign cpu_index = cpu_addr_i[13:2];

    assign cpu_read_data_o = cpu_read_data_r;
    assign pxl_data_o      = pxl_data_r;

    // read returns the old word on a write cycle
    always_ff @(posedge cpu_clk_i) begin
        if (cpu_chip_select_i) begin
            cpu_read_data_r <= mem_r[cpu_index];
            for (int lane = 0; lane < 4; lane++) begin
                if (cpu_write_mask_i[lane]) begin
                    mem_r[cpu_index][lane*8 +: 8] <= cpu_write_data_i[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_chip_select_i) begin
            pxl_data_r <= mem_r[pxl_addr_i];
        end
    end

endmodule

`default_nettype wire

/* src/cpu_bus_port.sv */
`default_nettype none

module cpu_bus_port
    import video_pkg::*;
    (
        input  wire logic       cpu_clk_i,
        input  wire logic       rst_n_i,

        // external four-phase bus
        input  wire logic       cpu_req_i,
        input  wire word_t      cpu_addr_i,
        input  wire word_t      cpu_wdata_i,
        input  wire logic [3:0] cpu_be_i,
        output logic            cpu_ack_o,
        output word_t           cpu_rdata_o,

        // video ram cpu port
        output logic            ram_cs_o,
        output word_t           ram_addr_o,
        output word_t           ram_wdata_o,
        output logic [3:0]      ram_mask_o,
        input  wire word_t      ram_rdata_i,

        reg_bus_if.master       reg_bus
    );

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_ACCESS   = 2'd1;
    localparam logic [1:0] ST_ACK      = 2'd2;
    localparam logic [1:0] ST_WAIT_REL = 2'd3;

    logic [1:0] state_r;
    logic       ack_r;
    word_t      rdata_r;
    logic       is_reg;
    logic       access;

    // address, data and enables are held by the cpu until ack
    assign is_reg = cpu_addr_i[14];
    assign access = (state_r == ST_ACCESS);

    assign ram_cs_o    = access && !is_reg;
    assign ram_addr_o  = cpu_addr_i;
    assign ram_wdata_o = cpu_wdata_i;
    assign ram_mask_o  = cpu_be_i;

    assign reg_bus.sel    = access && is_reg;
    assign reg_bus.offset = {cpu_addr_i[15:2], 2'b00};
    assign reg_bus.wdata  = cpu_wdata_i;
    assign reg_bus.write  = |cpu_be_i;

    assign cpu_ack_o   = ack_r;
    assign cpu_rdata_o = rdata_r;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_r <= ST_IDLE;
            ack_r   <= 1'b0;
        end else begin
            case (state_r)
                ST_IDLE: begin
                    // req only rises here after ack has dropped
                    if (cpu_req_i) begin
                        state_r <= ST_ACCESS;
                    end
                end
                ST_ACCESS: state_r <= ST_ACK;
                ST_ACK: begin
                    ack_r   <= 1'b1;
                    state_r <= ST_WAIT_REL;
                end
                ST_WAIT_REL: begin
                    if (!cpu_req_i) begin
                        ack_r   <= 1'b0;
                        state_r <= ST_IDLE;
                    end
                end
                default: state_r <= ST_IDLE;
            endcase
        end
    end

    // ram and register data both valid one cycle after the select
    always_ff @(posedge cpu_clk_i) begin
        if (state_r == ST_ACK) begin
            rdata_r <= is_reg ? reg_bus.rdata : ram_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* src/video_regs.sv */
`default_nettype none

`include "video_params.svh"

module video_regs
    import video_pkg::*;
    (
        input  wire logic   cpu_clk_i,
        input  wire logic   rst_n_i,
        reg_bus_if.slave    reg_bus,
        video_cfg_if.source cfg
    );

    // palette block covers 16 words from VID_REG_PAL
    localparam logic [15:0] PAL_MASK = 16'hffc0;

    logic [1:0]     ctrl_r;
    logic [11:0]    base_r;
    rgb444_t [15:0] pal_r;
    word_t          rdata_r;
    word_t          rd_mux;
    logic           hit_ctrl;
    logic           hit_base;
    logic           hit_pal;
    logic [3:0]     pal_idx;

    assign hit_ctrl = (reg_bus.offset == `VID_REG_CTRL);
    assign hit_base = (reg_bus.offset == `VID_REG_BASE);
    assign hit_pal  = ((reg_bus.offset & PAL_MASK) == `VID_REG_PAL);
    assign pal_idx  = reg_bus.offset[5:2];

    always_comb begin
        rd_mux = '0;
        if (hit_ctrl) begin
            rd_mux = {30'b0, ctrl_r};
        end else if (hit_base) begin
            rd_mux = {20'b0, base_r};
        end else if (hit_pal) begin
            rd_mux = {20'b0, pal_r[pal_idx]};
        end
    end

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_r  <= '0;
            base_r  <= '0;
            pal_r   <= '0;
            rdata_r <= '0;
        end else if (reg_bus.sel) begin
            rdata_r <= rd_mux;
            if (reg_bus.write) begin
                if (hit_ctrl) begin
                    ctrl_r <= reg_bus.wdata[1:0];
                end
                if (hit_base) begin
                    base_r <= reg_bus.wdata[11:0];
                end
                if (hit_pal) begin
                    pal_r[pal_idx] <= reg_bus.wdata[11:0];
                end
            end
        end
    end

    assign reg_bus.rdata = rdata_r;

    assign cfg.enable  = ctrl_r[0];
    assign cfg.mode    = ctrl_r[1];
    assign cfg.fb_base = base_r;
    assign cfg.palette = pal_r;

endmodule

`default_nettype wire

/* src/display_timing.sv */
`default_nettype none

`include "video_params.svh"

module display_timing (
        input  wire logic  pxl_clk_i,
        input  wire logic  rst_n_i,
        output logic [5:0] x_o,
        output logic [3:0] y_o,
        output logic       active_o,
        output logic       hsync_o,
        output logic       vsync_o
    );

    localparam int H_TOTAL  = `VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
    localparam int V_TOTAL  = `VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
    localparam int HS_START = `VID_H_ACTIVE + `VID_H_FRONT;
    localparam int VS_START = `VID_V_ACTIVE + `VID_V_FRONT;

    localparam logic [5:0] H_LAST   = 6'(H_TOTAL - 1);
    localparam logic [3:0] V_LAST   = 4'(V_TOTAL - 1);
    localparam logic [5:0] H_ACT    = 6'(`VID_H_ACTIVE);
    localparam logic [3:0] V_ACT    = 4'(`VID_V_ACTIVE);
    localparam logic [5:0] HS_FIRST = 6'(HS_START);
    localparam logic [5:0] HS_END   = 6'(HS_START + `VID_H_SYNC);
    localparam logic [3:0] VS_FIRST = 4'(VS_START);
    localparam logic [3:0] VS_END   = 4'(VS_START + `VID_V_SYNC);

    logic [5:0] h_cnt_r;
    logic [3:0] v_cnt_r;

    always_ff @(posedge pxl_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt_r <= '0;
            v_cnt_r <= '0;
        end else if (h_cnt_r == H_LAST) begin
            h_cnt_r <= '0;
            // end of line, advance and wrap the frame
            v_cnt_r <= (v_cnt_r == V_LAST) ? 4'd0 : v_cnt_r + 4'd1;
        end else begin
            h_cnt_r <= h_cnt_r + 6'd1;
        end
    end

    assign x_o      = h_cnt_r;
    assign y_o      = v_cnt_r;
    assign active_o = (h_cnt_r < H_ACT) && (v_cnt_r < V_ACT);
    assign hsync_o  = (h_cnt_r >= HS_FIRST) && (h_cnt_r < HS_END);
    assign vsync_o  = (v_cnt_r >= VS_FIRST) && (v_cnt_r < VS_END);

endmodule

`default_nettype wire

/* src/pixel_pipeline.sv */
`default_nettype none

module pixel_pipeline
    import video_pkg::*;
    (
        input  wire logic        pxl_clk_i,
        input  wire logic        rst_n_i,

        // raster position from the timing generator
        input  wire logic [5:0]  x_i,
        input  wire logic [3:0]  y_i,
        input  wire logic        active_i,
        input  wire logic        hsync_i,
        input  wire logic        vsync_i,

        video_cfg_if.sink        cfg,

        // video ram pixel port
        output logic             ram_cs_o,
        output logic [11:0]      ram_addr_o,
        input  wire word_t       ram_data_i,

        output rgb444_t          rgb_o,
        output logic             de_o,
        output logic             hsync_o,
        output logic             vsync_o
    );

    logic [11:0] line_off;
    logic [11:0] word_off;
    logic [2:0]  sub_r;
    logic        act_r;
    logic        hs_r;
    logic        vs_r;
    logic        en_meta_r;
    logic        en_sync_r;
    video_word_u vword;
    logic [15:0] px565;
    rgb444_t     colour;

    // packed: 4 words per line, direct: 16 words per line
    always_comb begin
        if (cfg.mode) begin
            line_off = {4'b0, y_i, 4'b0000};
            word_off = {7'b0, x_i[5:1]};
        end else begin
            line_off = {6'b0, y_i, 2'b00};
            word_off = {9'b0, x_i[5:3]};
        end
    end

    assign ram_cs_o   = active_i;
    assign ram_addr_o = cfg.fb_base + line_off + word_off;

    // stage 1, alongside the ram read
    always_ff @(posedge pxl_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_r <= 1'b0;
            hs_r  <= 1'b0;
            vs_r  <= 1'b0;
        end else begin
            act_r <= active_i;
            hs_r  <= hsync_i;
            vs_r  <= vsync_i;
        end
    end

    always_ff @(posedge pxl_clk_i) begin
        sub_r <= x_i[2:0];
    end

    // enable comes from the cpu clock domain
    always_ff @(posedge pxl_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_meta_r <= 1'b0;
            en_sync_r <= 1'b0;
        end else begin
            en_meta_r <= cfg.enable;
            en_sync_r <= en_meta_r;
        end
    end

    assign vword = ram_data_i;
    assign px565 = vword.rgb565[sub_r[0]];

    // rgb565 keeps the top 4 bits of each channel
    assign colour = cfg.mode ? {px565[15:12], px565[10:7], px565[4:1]}
                             : cfg.palette[vword.idx[sub_r]];

    // stage 2, registered outputs
    always_ff @(posedge pxl_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rgb_o   <= '0;
            de_o    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
        end else begin
            rgb_o   <= (act_r && en_sync_r) ? colour : '0;
            de_o    <= act_r;
            hsync_o <= hs_r;
            vsync_o <= vs_r;
        end
    end

endmodule

`default_nettype wire

/* src/video_top.sv */
`default_nettype none

module video_top
    import video_pkg::*;
    (
        input  wire logic       cpu_clk_i,
        input  wire logic       pxl_clk_i,
        input  wire logic       rst_n_i,

        input  wire logic       cpu_req_i,
        input  wire word_t      cpu_addr_i,
        input  wire word_t      cpu_wdata_i,
        input  wire logic [3:0] cpu_be_i,
        output word_t           cpu_rdata_o,
        output logic            cpu_ack_o,

        output rgb444_t         rgb_o,
        output logic            de_o,
        output logic            hsync_o,
        output logic            vsync_o
    );

    // ram cpu port
    logic        ram_cs;
    word_t       ram_addr;
    word_t       ram_wdata;
    logic [3:0]  ram_mask;
    word_t       ram_rdata;

    // ram pixel port
    logic        pxl_cs;
    logic [11:0] pxl_addr;
    word_t       pxl_data;

    // raster position
    logic [5:0]  tim_x;
    logic [3:0]  tim_y;
    logic        tim_active;
    logic        tim_hsync;
    logic        tim_vsync;

    reg_bus_if   reg_bus ();
    video_cfg_if vid_cfg ();

    cpu_bus_port u_bus (
        .cpu_clk_i   (cpu_clk_i),
        .rst_n_i     (rst_n_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_be_i    (cpu_be_i),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_rdata_o (cpu_rdata_o),
        .ram_cs_o    (ram_cs),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_mask_o  (ram_mask),
        .ram_rdata_i (ram_rdata),
        .reg_bus     (reg_bus.master)
    );

    video_regs u_regs (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .reg_bus   (reg_bus.slave),
        .cfg       (vid_cfg.source)
    );

    video_ram u_ram (
        .cpu_clk_i         (cpu_clk_i),
        .cpu_chip_select_i (ram_cs),
        .cpu_addr_i        (ram_addr),
        .cpu_write_data_i  (ram_wdata),
        .cpu_write_mask_i  (ram_mask),
        .cpu_read_data_o   (ram_rdata),
        .pxl_clk_i         (pxl_clk_i),
        .pxl_chip_select_i (pxl_cs),
        .pxl_addr_i        (pxl_addr),
        .pxl_data_o        (pxl_data)
    );

    display_timing u_timing (
        .pxl_clk_i (pxl_clk_i),
        .rst_n_i   (rst_n_i),
        .x_o       (tim_x),
        .y_o       (tim_y),
        .active_o  (tim_active),
        .hsync_o   (tim_hsync),
        .vsync_o   (tim_vsync)
    );

    pixel_pipeline u_pixel (
        .pxl_clk_i  (pxl_clk_i),
        .rst_n_i    (rst_n_i),
        .x_i        (tim_x),
        .y_i        (tim_y),
        .active_i   (tim_active),
        .hsync_i    (tim_hsync),
        .vsync_i    (tim_vsync),
        .cfg        (vid_cfg.sink),
        .ram_cs_o   (pxl_cs),
        .ram_addr_o (pxl_addr),
        .ram_data_i (pxl_data),
        .rgb_o      (rgb_o),
        .de_o       (de_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o)
    );

endmodule

`default_nettype wire

/* tests/video_assertions.sv */
`default_nettype none

module video_assertions (
        input wire logic cpu_clk_i,
        input wire logic pxl_clk_i,
        input wire logic rst_n_i,
        input wire logic cpu_req_i,
        input wire logic cpu_ack_o,
        input wire logic de_o,
        input wire logic hsync_o,
        input wire logic vsync_o
    );
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed properties so far
    int unsigned fail_count = 0;

    // four-phase bus, slave side
    ack_needs_req: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        $rose(cpu_ack_o) |-> cpu_req_i)
        else begin
            fail_count++;
            $error("cpu_ack_o rose while cpu_req_i was low");
        end

    ack_held_until_release: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        $fell(cpu_ack_o) |-> !$past(cpu_req_i))
        else begin
            fail_count++;
            $error("cpu_ack_o fell while cpu_req_i was still high");
        end

    // no sync inside the active area
    sync_outside_active: assert property (@(posedge pxl_clk_i) disable iff (!rst_n_i)
        de_o |-> (!hsync_o && !vsync_o))
        else begin
            fail_count++;
            $error("hsync_o or vsync_o high while de_o is high");
        end

endmodule

bind video_top video_assertions u_assertions (
    .cpu_clk_i (cpu_clk_i),
    .pxl_clk_i (pxl_clk_i),
    .rst_n_i   (rst_n_i),
    .cpu_req_i (cpu_req_i),
    .cpu_ack_o (cpu_ack_o),
    .de_o      (de_o),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o)
);

`default_nettype wire

/* tests/video_tb.sv */
`default_nettype none

`include "video_params.svh"

module video_tb
    import video_pkg::*;
    ();
    timeunit 1ns;
    timeprecision 1ps;

    // 12 frames of 480 pixel clocks, 300 bus accesses of 10 cpu cycles, reset
    localparam int unsigned WATCHDOG_NS = 12 * 480 * 40 + 300 * 10 * 20 + 8 * 20;

    logic       cpu_clk_i = 1'b0;
    logic       pxl_clk_i = 1'b0;
    logic       rst_n_i;
    logic       cpu_req_i;
    word_t      cpu_addr_i;
    word_t      cpu_wdata_i;
    logic [3:0] cpu_be_i;
    word_t      cpu_rdata_o;
    logic       cpu_ack_o;
    rgb444_t    rgb_o;
    logic       de_o;
    logic       hsync_o;
    logic       vsync_o;

    integer      seed = 32'hc819;
    word_t       shadow_mem [0:`VID_RAM_WORDS-1];
    rgb444_t     shadow_pal [0:15];
    logic        shadow_enable = 1'b0;
    logic        shadow_mode = 1'b0;
    logic [11:0] shadow_base = 12'h000;

    always #10 cpu_clk_i = ~cpu_clk_i;
    always #20 pxl_clk_i = ~pxl_clk_i;

    video_top DUT (
        .cpu_clk_i   (cpu_clk_i),
        .pxl_clk_i   (pxl_clk_i),
        .rst_n_i     (rst_n_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_be_i    (cpu_be_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_ack_o   (cpu_ack_o),
        .rgb_o       (rgb_o),
        .de_o        (de_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o)
    );

    task automatic check_equal(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got 0x%08h expected 0x%08h", $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one four-phase handshake
    task automatic bus_access(input word_t addr, input word_t wdata, input logic [3:0] be,
                              output word_t rdata);
        @(posedge cpu_clk_i);
        cpu_req_i   <= 1'b1;
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        cpu_be_i    <= be;
        @(posedge cpu_clk_i);
        while (!cpu_ack_o) @(posedge cpu_clk_i);
        rdata = cpu_rdata_o;
        cpu_req_i <= 1'b0;
        @(posedge cpu_clk_i);
        while (cpu_ack_o) @(posedge cpu_clk_i);
    endtask

    task automatic ram_write(input logic [11:0] idx, input word_t data, input logic [3:0] be);
        word_t unused;
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        bus_access({18'b0, idx, 2'b00}, data, be, unused);
        shadow_mem[idx] = (shadow_mem[idx] & ~mask) | (data & mask);
    endtask

    task automatic ram_read(input logic [11:0] idx, output word_t rdata);
        bus_access({18'b0, idx, 2'b00}, 32'h0, 4'h0, rdata);
    endtask

    task automatic reg_write(input word_t addr, input word_t data);
        word_t unused;
        bus_access(addr, data, 4'hf, unused);
    endtask

    task automatic reg_read(input word_t addr, output word_t rdata);
        bus_access(addr, 32'h0, 4'h0, rdata);
    endtask

    task automatic set_ctrl(input logic en, input logic mode);
        reg_write(32'(`VID_REG_CTRL), {30'b0, mode, en});
        shadow_enable = en;
        shadow_mode   = mode;
    endtask

    task automatic set_base(input logic [11:0] base);
        reg_write(32'(`VID_REG_BASE), {20'b0, base});
        shadow_base = base;
    endtask

    task automatic load_palette();
        word_t      data;
        logic [3:0] pidx;
        for (int i = 0; i < 16; i++) begin
            pidx = 4'(i);
            data = $random(seed);
            reg_write(32'(`VID_REG_PAL) + {26'b0, pidx, 2'b00}, data);
            shadow_pal[pidx] = data[11:0];
        end
    endtask

    // colour expected at raster position (x, y) under the current setup
    function automatic rgb444_t expected_pixel(input int x, input int y);
        word_t       w;
        logic [11:0] idx;
        logic [15:0] half;
        logic [4:0]  lsb;
        if (!shadow_enable) begin
            return 12'h000;
        end
        if (shadow_mode) begin
            idx  = shadow_base + 12'(y * 16 + x / 2);
            w    = shadow_mem[idx];
            half = x[0] ? w[31:16] : w[15:0];
            return {half[15:12], half[10:7], half[4:1]};
        end
        idx = shadow_base + 12'(y * 4 + x / 8);
        w   = shadow_mem[idx];
        lsb = 5'(4 * (x % 8));
        return shadow_pal[w[lsb +: 4]];
    endfunction

    task automatic wait_vsync_rise();
        logic prev;
        logic cur;
        cur = 1'b1;
        do begin
            prev = cur;
            @(posedge pxl_clk_i);
            cur = vsync_o;
        end while (!(cur && !prev));
    endtask

    // checks every pixel, the de geometry and the hsync pulses between two vsync pulses
    task automatic check_frame();
        int   x;
        int   y;
        int   hs_run;
        int   hs_pulses;
        logic vs_prev;
        logic rose;
        wait_vsync_rise();
        x         = 0;
        y         = 0;
        hs_run    = 0;
        hs_pulses = 0;
        vs_prev   = 1'b1;
        do begin
            @(posedge pxl_clk_i);
            if (de_o) begin
                check_equal("rgb_o", 32'(rgb_o), 32'(expected_pixel(x, y)));
                x++;
            end else if (x != 0) begin
                check_equal("de_run_length", x, 32);
                x = 0;
                y++;
            end
            if (hsync_o) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_equal("hsync_width", hs_run, `VID_H_SYNC);
                hs_run = 0;
                hs_pulses++;
            end
            rose    = vsync_o && !vs_prev;
            vs_prev = vsync_o;
        end while (!rose);
        check_equal("active_lines", y, 8);
        // one line sync per raster line
        check_equal("hsync_pulses", hs_pulses,
                    `VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK);
    endtask

    task automatic test_ram_access();
        word_t       rd;
        logic [11:0] idx;
        logic [3:0]  be;
        for (int i = 0; i < 12; i++) begin
            idx = 12'(i * 37 + 5);
            ram_write(idx, $random(seed), 4'hf);
            be = 4'($random(seed));
            // zero enables would turn the access into a read
            if (be == 4'h0) begin
                be = 4'b0101;
            end
            ram_write(idx, $random(seed), be);
            ram_read(idx, rd);
            check_equal("cpu_rdata_o", rd, shadow_mem[idx]);
        end
    endtask

    task automatic test_registers();
        word_t      rd;
        logic [3:0] pidx;
        reg_write(32'(`VID_REG_CTRL), 32'hffff_fffe);
        reg_read(32'(`VID_REG_CTRL), rd);
        check_equal("ctrl", rd, 32'h0000_0002);
        reg_write(32'(`VID_REG_BASE), 32'h1234_5abc);
        reg_read(32'(`VID_REG_BASE), rd);
        check_equal("base", rd, 32'h0000_0abc);
        load_palette();
        for (int i = 0; i < 16; i++) begin
            pidx = 4'(i);
            reg_read(32'(`VID_REG_PAL) + {26'b0, pidx, 2'b00}, rd);
            check_equal("palette", rd, {20'b0, shadow_pal[pidx]});
        end
        // unmapped offsets
        reg_write(32'h0000_4008, 32'hffff_ffff);
        reg_write(32'h0000_4080, 32'hffff_ffff);
        reg_read(32'h0000_4008, rd);
        check_equal("unmapped_4008", rd, 32'h0);
        reg_read(32'h0000_4080, rd);
        check_equal("unmapped_4080", rd, 32'h0);
        reg_read(32'(`VID_REG_CTRL), rd);
        check_equal("ctrl", rd, 32'h0000_0002);
        reg_read(32'(`VID_REG_BASE), rd);
        check_equal("base", rd, 32'h0000_0abc);
        reg_read(32'(`VID_REG_PAL), rd);
        check_equal("palette", rd, {20'b0, shadow_pal[0]});
        set_ctrl(1'b0, 1'b0);
        set_base(12'h000);
    endtask

    task automatic test_disabled_display();
        set_ctrl(1'b0, 1'b0);
        check_frame();
    endtask

    task automatic test_packed_mode();
        set_base(12'h000);
        load_palette();
        for (int i = 0; i < 32; i++) begin
            ram_write(12'(i), $random(seed), 4'hf);
        end
        set_ctrl(1'b1, 1'b0);
        check_frame();
    endtask

    task automatic test_direct_mode();
        set_ctrl(1'b0, 1'b0);
        set_ctrl(1'b0, 1'b1);
        // base close to the top so the frame wraps at 12 bits
        set_base(12'hfc8);
        for (int i = 0; i < 128; i++) begin
            ram_write(shadow_base + 12'(i), $random(seed), 4'hf);
        end
        set_ctrl(1'b1, 1'b1);
        check_frame();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        rst_n_i     = 1'b0;
        cpu_req_i   = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_be_i    = '0;
        for (int i = 0; i < `VID_RAM_WORDS; i++) begin
            shadow_mem[12'(i)] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            shadow_pal[4'(i)] = '0;
        end
        repeat (8) @(posedge cpu_clk_i);
        rst_n_i <= 1'b1;

        test_ram_access();
        test_registers();
        test_disabled_display();
        test_packed_mode();
        test_direct_mode();

        // bound protocol checks report through their own counter
        if (DUT.u_assertions.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
src/video_pkg.sv
src/video_ifs.sv
src/video_ram.sv
src/cpu_bus_port.sv
src/video_regs.sv
src/display_timing.sv
src/pixel_pipeline.sv
src/video_top.sv
tests/video_assertions.sv
tests/video_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := video_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
